// File: list.f
hw/lcPkg.sv
hw/lcStateDecode.sv
hw/lcTransCheck.sv
hw/lcFsm.sv
hw/lcCtrl.sv
verif/lcCtrlTb.sv

// File: Bender.yml
package:
  name: lcCtrl

sources:
  - hw/lcPkg.sv
  - hw/lcStateDecode.sv
  - hw/lcTransCheck.sv
  - hw/lcFsm.sv
  - hw/lcCtrl.sv
  - target: test
    files:
      - verif/lcCtrlTb.sv

// File: verif/lcCtrlTb.sv
/*
 * Life cycle controller testbench
 * Directed tests for reset, decoding, corrupted inputs,
 * accepted and refused transitions and escalation
 */

`timescale 1ns/1ps

module lcCtrlTb
  import lcPkg::*;
;

  localparam int ClkPeriod      = 20;
  localparam int NumTests       = 5;
  // Run limit scales with the number of tests
  localparam int WatchdogCycles = NumTests * 200;

  logic                                clk;
  logic                                arstN;
  logic                                otpValid;
  lcStateE                             lcState;
  lcCntE                               lcCnt;
  lcTxE                                secretsValid;
  logic                                escalate;
  logic                                transReq;
  lcStateE                             transTarget;
  decLcStateE [DecLcStateNumRep-1:0]   decState;
  decLcIdStateE                        decIdState;
  logic [DecLcCntWidth-1:0]            decCnt;
  logic [NumStateErrors-1:0]           stateErr;
  logic                                otpProgReq;
  lcStateE                             otpProgState;
  lcCntE                               otpProgCnt;
  logic                                transError;
  logic                                transDone;

  integer seed;
  int     errCount;
  int     checkCount;

  // Reference tables, index 0 to 7 is Raw to Scrap
  lcStateE    stTab  [8];
  decLcStateE decTab [8];
  lcCntE      cntTab [9];
  // Allowed targets per source state, bit j for target j
  logic [7:0] allowedMask [8];

  lcCtrl dut0 (
    .clk_i               (clk),
    .arstN_i             (arstN),
    .otpValid_i          (otpValid),
    .lcState_i           (lcState),
    .lcCnt_i             (lcCnt),
    .secretsValid_i      (secretsValid),
    .escalate_i          (escalate),
    .transReq_i          (transReq),
    .transTarget_i       (transTarget),
    .decState_o          (decState),
    .decIdState_o        (decIdState),
    .decCnt_o            (decCnt),
    .stateInvalidError_o (stateErr),
    .otpProgReq_o        (otpProgReq),
    .otpProgState_o      (otpProgState),
    .otpProgCnt_o        (otpProgCnt),
    .transError_o        (transError),
    .transDone_o         (transDone)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic loadTables();
    stTab  = '{LcStRaw, LcStTestUnlocked0, LcStTestLocked0, LcStDev,
               LcStProd, LcStProdEnd, LcStRma, LcStScrap};
    decTab = '{DecLcStRaw, DecLcStTestUnlocked0, DecLcStTestLocked0, DecLcStDev,
               DecLcStProd, DecLcStProdEnd, DecLcStRma, DecLcStScrap};
    cntTab = '{LcCnt0, LcCnt1, LcCnt2, LcCnt3, LcCnt4,
               LcCnt5, LcCnt6, LcCnt7, LcCnt8};
    // Raw, TestUnlocked0, TestLocked0, Dev, Prod, ProdEnd, Rma, Scrap
    allowedMask = '{8'b1000_0010, 8'b1101_1100, 8'b1001_1010, 8'b1100_0000,
                    8'b1100_0000, 8'b1000_0000, 8'b1000_0000, 8'b0000_0000};
  endtask

  task automatic checkVal(input string name, input logic [31:0] expVal,
                          input logic [31:0] actVal);
    checkCount++;
    if (expVal !== actVal) begin
      errCount++;
      $display("error at %0d ns: %s expected %0h, got %0h", $time, name, expVal, actVal);
    end
  endtask

  task automatic checkDecState(input decLcStateE expSt);
    for (int k = 0; k < DecLcStateNumRep; k++) begin
      checkVal($sformatf("decState_o[%0d]", k), expSt, decState[k]);
    end
  endtask

  task automatic reportTest(input string name, input int errStart);
    $display("test %s finished, %0d errors", name, errCount - errStart);
  endtask

  function automatic logic isStateCode(input logic [15:0] v);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (v == stTab[i]) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic logic isCntCode(input logic [15:0] v);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 9; i++) begin
      if (v == cntTab[i]) hit = 1'b1;
    end
    return hit;
  endfunction

  // Reset with a given OTP view, returns after the edge that leaves ResetSt
  task automatic applyReset(input logic valid, input int st, input int cn, input lcTxE sec);
    @(negedge clk);
    arstN        = 1'b0;
    otpValid     = valid;
    lcState      = stTab[st];
    lcCnt        = cntTab[cn];
    secretsValid = sec;
    transReq     = 1'b0;
    escalate     = 1'b0;
    repeat (8) @(negedge clk);
    arstN = 1'b1;
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic testAfterReset();
    int errStart;
    errStart = errCount;
    applyReset(1'b0, 0, 0, Off);
    repeat (2) @(negedge clk);
    #5;
    // Still in ResetSt without a valid OTP view
    checkDecState(DecLcStInvalid);
    checkVal("decIdState_o", DecLcIdInvalid, decIdState);
    checkVal("decCnt_o", 4'hf, decCnt);
    checkVal("stateInvalidError_o", 6'd0, stateErr);
    checkVal("otpProgReq_o", 1'b0, otpProgReq);
    checkVal("transError_o", 1'b0, transError);
    checkVal("transDone_o", 1'b0, transDone);
    reportTest("afterReset", errStart);
  endtask

  task automatic testDecodeAll();
    int                        errStart;
    logic                      mustReset;
    lcTxE                      sec;
    logic [NumStateErrors-1:0] expErr;
    errStart  = errCount;
    mustReset = 1'b1;
    for (int s = 0; s < 8; s++) begin
      for (int c = 0; c < 9; c++) begin
        for (int t = 0; t < 2; t++) begin
          sec = (t == 0) ? Off : On;
          // Errors or Scrap leave IdleSt on the next edge
          if (mustReset) applyReset(1'b1, s, c, sec);
          @(negedge clk);
          lcState      = stTab[s];
          lcCnt        = cntTab[c];
          secretsValid = sec;
          expErr       = '0;
          expErr[4]    = (s != 0) && (c == 0);
          expErr[5]    = (sec == On) && (s < 3);
          #5;
          checkDecState(decTab[s]);
          checkVal("decCnt_o", c, decCnt);
          checkVal("decIdState_o", (sec == On) ? DecLcIdPersonalized : DecLcIdBlank,
                   decIdState);
          checkVal("stateInvalidError_o", expErr, stateErr);
          mustReset = (expErr != '0) || (s == 7);
        end
      end
    end
    reportTest("decodeAll", errStart);
  endtask

  task automatic testCorrupt();
    int          errStart;
    logic [15:0] raw;
    logic [3:0]  rawTx;
    errStart = errCount;

    // Corrupted state code, Dev with count 3 otherwise
    applyReset(1'b1, 3, 3, Off);
    raw = $random(seed);
    while (isStateCode(raw)) raw = $random(seed);
    @(negedge clk);
    lcState = lcStateE'(raw);
    #5;
    checkVal("stateInvalidError_o", 6'b000010, stateErr);
    checkDecState(DecLcStInvalid);
    @(negedge clk);
    #5;
    checkDecState(DecLcStInvalid);

    // Corrupted counter code
    applyReset(1'b1, 3, 3, Off);
    raw = $random(seed);
    while (isCntCode(raw)) raw = $random(seed);
    @(negedge clk);
    lcCnt = lcCntE'(raw);
    #5;
    checkVal("stateInvalidError_o", 6'b000100, stateErr);
    checkVal("decCnt_o", 4'hf, decCnt);
    @(negedge clk);
    #5;
    checkDecState(DecLcStInvalid);

    // Corrupted secrets flag
    applyReset(1'b1, 3, 3, Off);
    rawTx = $random(seed);
    while (rawTx == 4'b0101 || rawTx == 4'b1010) rawTx = $random(seed);
    @(negedge clk);
    secretsValid = lcTxE'(rawTx);
    #5;
    checkVal("stateInvalidError_o", 6'b001000, stateErr);
    checkVal("decIdState_o", DecLcIdInvalid, decIdState);
    @(negedge clk);
    #5;
    checkDecState(DecLcStInvalid);
    reportTest("corrupt", errStart);
  endtask

  task automatic testAccept();
    int errStart;
    int st;
    int tg;
    int cn;
    errStart = errCount;
    for (int n = 0; n < 4; n++) begin
      // Random allowed pair, Raw is the only state with count 0
      st = {$random(seed)} % 7;
      tg = {$random(seed)} % 8;
      while (!allowedMask[st][tg]) tg = {$random(seed)} % 8;
      cn = (st == 0) ? ({$random(seed)} % 8) : (1 + {$random(seed)} % 7);
      applyReset(1'b1, st, cn, Off);
      @(negedge clk);
      transReq    = 1'b1;
      transTarget = stTab[tg];
      @(negedge clk);
      transReq = 1'b0;
      #5;
      checkVal("otpProgReq_o", 1'b1, otpProgReq);
      checkVal("otpProgState_o", stTab[tg], otpProgState);
      checkVal("otpProgCnt_o", cntTab[cn + 1], otpProgCnt);
      checkVal("transError_o", 1'b0, transError);
      @(negedge clk);
      #5;
      checkVal("otpProgReq_o", 1'b0, otpProgReq);
      checkVal("transDone_o", 1'b1, transDone);
      checkDecState(DecLcStPostTrans);
    end
    reportTest("accept", errStart);
  endtask

  // One refused request from a given view, the pulse must come alone
  task automatic refuseOnce(input int st, input int cn, input int tg);
    applyReset(1'b1, st, cn, Off);
    @(negedge clk);
    transReq    = 1'b1;
    transTarget = stTab[tg];
    @(negedge clk);
    transReq = 1'b0;
    #5;
    checkVal("transError_o", 1'b1, transError);
    checkVal("otpProgReq_o", 1'b0, otpProgReq);
    @(negedge clk);
    #5;
    checkVal("transError_o", 1'b0, transError);
    checkVal("otpProgReq_o", 1'b0, otpProgReq);
    checkVal("transDone_o", 1'b0, transDone);
  endtask

  task automatic testRefuse();
    int errStart;
    int st;
    int tg;
    errStart = errCount;
    // Pair outside the matrix
    st = {$random(seed)} % 7;
    tg = {$random(seed)} % 8;
    while (allowedMask[st][tg]) tg = {$random(seed)} % 8;
    refuseOnce(st, 1 + {$random(seed)} % 7, tg);
    // Allowed pair but the counter is exhausted
    refuseOnce(1, 8, 3);
    // Escalation from IdleSt is terminal
    @(negedge clk);
    escalate = 1'b1;
    @(negedge clk);
    escalate = 1'b0;
    #5;
    checkDecState(DecLcStEscalate);
    @(negedge clk);
    #5;
    checkDecState(DecLcStEscalate);
    reportTest("refuse", errStart);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    arstN        = 1'b0;
    otpValid     = 1'b0;
    lcState      = LcStRaw;
    lcCnt        = LcCnt0;
    secretsValid = Off;
    escalate     = 1'b0;
    transReq     = 1'b0;
    transTarget  = LcStRaw;
    seed         = 32'h67dd7ebf;
    errCount     = 0;
    checkCount   = 0;
    loadTables();

    testAfterReset();
    testDecodeAll();
    testCorrupt();
    testAccept();
    testRefuse();

    $display("tests %0d, checks %0d, errors %0d", NumTests, checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired after %0d cycles, tests did not finish", WatchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: hw/lcCtrl.sv
/*
 * Life cycle controller top
 * Connects the main FSM, the state decoder and the transition checker
 */

`timescale 1ns/1ps

module lcCtrl
  import lcPkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   arstN_i,
  // OTP state vector
  input  logic                                   otpValid_i,
  input  lcStateE                                lcState_i,
  input  lcCntE                                  lcCnt_i,
  input  lcTxE                                   secretsValid_i,
  // Escalation and transition request
  input  logic                                   escalate_i,
  input  logic                                   transReq_i,
  input  lcStateE                                transTarget_i,
  // Decoded view
  output decLcStateE [DecLcStateNumRep-1:0]      decState_o,
  output decLcIdStateE                           decIdState_o,
  output logic       [DecLcCntWidth-1:0]         decCnt_o,
  output logic       [NumStateErrors-1:0]        stateInvalidError_o,
  // OTP programming and status
  output logic                                   otpProgReq_o,
  output lcStateE                                otpProgState_o,
  output lcCntE                                  otpProgCnt_o,
  output logic                                   transError_o,
  output logic                                   transDone_o
);

  fsmStateE fsmState;
  logic     transOk;
  lcCntE    nextCnt;

  // Main FSM
  lcFsm fsm0 (
    .clk_i               (clk_i),
    .arstN_i             (arstN_i),
    .otpValid_i          (otpValid_i),
    .escalate_i          (escalate_i),
    .transReq_i          (transReq_i),
    .transTarget_i       (transTarget_i),
    .lcState_i           (lcState_i),
    .stateInvalidError_i (stateInvalidError_o),
    .transOk_i           (transOk),
    .nextCnt_i           (nextCnt),
    .fsmState_o          (fsmState),
    .otpProgReq_o        (otpProgReq_o),
    .otpProgState_o      (otpProgState_o),
    .otpProgCnt_o        (otpProgCnt_o),
    .transError_o        (transError_o),
    .transDone_o         (transDone_o)
  );

  // Decoder, follows the FSM state in the same cycle
  lcStateDecode stateDecode0 (
    .otpValid_i          (otpValid_i),
    .lcState_i           (lcState_i),
    .lcCnt_i             (lcCnt_i),
    .secretsValid_i      (secretsValid_i),
    .fsmState_i          (fsmState),
    .decState_o          (decState_o),
    .decIdState_o        (decIdState_o),
    .decCnt_o            (decCnt_o),
    .stateInvalidError_o (stateInvalidError_o)
  );

  // Transition rules
  lcTransCheck transCheck0 (
    .lcState_i     (lcState_i),
    .lcCnt_i       (lcCnt_i),
    .transTarget_i (transTarget_i),
    .transOk_o     (transOk),
    .nextCnt_o     (nextCnt)
  );

endmodule

// File: hw/lcFsm.sv
/*
 * Life cycle main FSM
 * Sequences reset, idle, transition, escalation and invalid
 * handling and issues the OTP programming and error pulses
 */

`timescale 1ns/1ps

module lcFsm
  import lcPkg::*;
(
  input  logic                      clk_i,
  input  logic                      arstN_i,
  // OTP and escalation status
  input  logic                      otpValid_i,
  input  logic                      escalate_i,
  // Transition request
  input  logic                      transReq_i,
  input  lcStateE                   transTarget_i,
  // Current state and decoder errors
  input  lcStateE                   lcState_i,
  input  logic [NumStateErrors-1:0] stateInvalidError_i,
  // Checker verdict
  input  logic                      transOk_i,
  input  lcCntE                     nextCnt_i,
  // FSM state for the decoder
  output fsmStateE                  fsmState_o,
  // OTP programming
  output logic                      otpProgReq_o,
  output lcStateE                   otpProgState_o,
  output lcCntE                     otpProgCnt_o,
  // Status pulses and levels
  output logic                      transError_o,
  output logic                      transDone_o
);

  fsmStateE stateD;
  fsmStateE stateQ;
  logic     progReqD;
  logic     transErrD;

  //////////////////////////////////////////////////
  // Next state logic
  //////////////////////////////////////////////////

  always_comb begin
    stateD    = stateQ;
    progReqD  = 1'b0;
    transErrD = 1'b0;

    case (stateQ)
      // Wait for OTP to present a valid state
      ResetSt: begin
        if (otpValid_i) begin
          stateD = IdleSt;
        end
      end
      IdleSt: begin
        // Priority: escalation, errors, scrap, request
        if (escalate_i) begin
          stateD = EscalateSt;
        end else if (|stateInvalidError_i) begin
          stateD = InvalidSt;
        end else if (lcState_i == LcStScrap) begin
          stateD = ScrapSt;
        end else if (transReq_i) begin
          if (transOk_i) begin
            stateD   = PostTransSt;
            progReqD = 1'b1;
          end else begin
            transErrD = 1'b1;
          end
        end
      end
      // Terminal until reset, escalation still wins
      PostTransSt, InvalidSt, ScrapSt: begin
        if (escalate_i) begin
          stateD = EscalateSt;
        end
      end
      EscalateSt: ;
      // Corrupted state register
      default: stateD = InvalidSt;
    endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      stateQ       <= ResetSt;
      otpProgReq_o <= 1'b0;
      transError_o <= 1'b0;
      transDone_o  <= 1'b0;
    end else begin
      stateQ       <= stateD;
      otpProgReq_o <= progReqD;
      transError_o <= transErrD;
      // Sticky once a transition went out
      if (progReqD) begin
        transDone_o <= 1'b1;
      end
    end
  end

  // Programming payload, captured with the request
  always_ff @(posedge clk_i) begin
    if (progReqD) begin
      otpProgState_o <= transTarget_i;
      otpProgCnt_o   <= nextCnt_i;
    end
  end

  assign fsmState_o = stateQ;

  // Assertions
  progReqPulseA: assert property (@(posedge clk_i) disable iff (!arstN_i)
    otpProgReq_o |=> !otpProgReq_o)
    else $error("otpProgReq_o held for more than one cycle");

  progErrExclA: assert property (@(posedge clk_i) disable iff (!arstN_i)
    !(otpProgReq_o && transError_o))
    else $error("otpProgReq_o and transError_o high together");

endmodule

// File: hw/lcTransCheck.sv
/*
 * Transition checker
 * Applies the transition matrix and the counter limit
 * and forms the incremented counter code
 */

`timescale 1ns/1ps

module lcTransCheck
  import lcPkg::*;
(
  // Current OTP state and count
  input  lcStateE lcState_i,
  input  lcCntE   lcCnt_i,
  // Requested target
  input  lcStateE transTarget_i,
  // Verdict and the count to program
  output logic    transOk_o,
  output lcCntE   nextCnt_o
);

  logic [DecLcCntWidth-1:0] cntDec;
  logic [DecLcCntWidth-1:0] cntInc;
  logic                     pairOk;
  logic                     cntOk;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Invalid counter codes decode to all ones and fail the limit
  assign cntDec = lcCntToDec(lcCnt_i);
  assign cntOk  = (cntDec < DecLcCntWidth'(LcCntMax));

  // Matrix lookup, invalid targets are refused inside the helper
  assign pairOk = lcTransAllowed(lcState_i, transTarget_i);

  assign transOk_o = pairOk & cntOk;

  //////////////////////////////////////////////////
  // Next count
  //////////////////////////////////////////////////

  assign cntInc = cntDec + 4'd1;

  // Hold the current code when the count cannot advance
  always_comb begin
    if (cntOk) begin
      nextCnt_o = lcCntFromDec(cntInc);
    end else begin
      nextCnt_o = lcCnt_i;
    end
  end

endmodule

// File: hw/lcStateDecode.sv
/*
 * Life cycle state decoder
 * Turns the sparse OTP state, counter and secrets flag into
 * the dense view for software and flags corrupted inputs
 */

`timescale 1ns/1ps

module lcStateDecode
  import lcPkg::*;
(
  // Raw values from OTP
  input  logic                                   otpValid_i,
  input  lcStateE                                lcState_i,
  input  lcCntE                                  lcCnt_i,
  input  lcTxE                                   secretsValid_i,
  // Current main FSM state
  input  fsmStateE                               fsmState_i,
  // Decoded view
  output decLcStateE [DecLcStateNumRep-1:0]      decState_o,
  output decLcIdStateE                           decIdState_o,
  output logic       [DecLcCntWidth-1:0]         decCnt_o,
  output logic       [NumStateErrors-1:0]        stateInvalidError_o
);

  // Single decoded state, fanned out to the copies below
  decLcStateE                 decState;
  logic [DecLcCntWidth-1:0]   cntDec;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  always_comb begin
    // Defaults, also the ResetSt view
    decState            = DecLcStInvalid;
    decIdState_o        = DecLcIdInvalid;
    decCnt_o            = {DecLcCntWidth{1'b1}};
    stateInvalidError_o = '0;
    cntDec              = lcCntToDec(lcCnt_i);

    case (fsmState_i)
      // Temporary states override whatever OTP holds
      EscalateSt:  decState = DecLcStEscalate;
      PostTransSt: decState = DecLcStPostTrans;
      InvalidSt:   decState = DecLcStInvalid;
      ScrapSt:     decState = DecLcStScrap;
      IdleSt: begin
        // OTP must stay valid once out of reset
        stateInvalidError_o[0] = ~otpValid_i;

        case (lcState_i)
          LcStRaw:           decState = DecLcStRaw;
          LcStTestUnlocked0: decState = DecLcStTestUnlocked0;
          LcStTestLocked0:   decState = DecLcStTestLocked0;
          LcStDev:           decState = DecLcStDev;
          LcStProd:          decState = DecLcStProd;
          LcStProdEnd:       decState = DecLcStProdEnd;
          LcStRma:           decState = DecLcStRma;
          LcStScrap:         decState = DecLcStScrap;
          default:           stateInvalidError_o[1] = 1'b1;
        endcase

        // Invalid counter codes map to all ones
        decCnt_o = cntDec;
        if (cntDec == {DecLcCntWidth{1'b1}}) begin
          stateInvalidError_o[2] = 1'b1;
        end

        case (secretsValid_i)
          Off:     decIdState_o = DecLcIdBlank;
          On:      decIdState_o = DecLcIdPersonalized;
          default: stateInvalidError_o[3] = 1'b1;
        endcase

        // Every state past Raw took at least one transition
        if (lcState_i != LcStRaw && lcCnt_i == LcCnt0) begin
          stateInvalidError_o[4] = 1'b1;
        end

        // Secrets only exist in mission and end of life states
        if (secretsValid_i == On &&
            !(lcState_i inside {LcStDev, LcStProd, LcStProdEnd, LcStRma, LcStScrap})) begin
          stateInvalidError_o[5] = 1'b1;
        end
      end
      // ResetSt and unknown FSM codes keep the defaults
      default: ;
    endcase
  end

  // Redundant copies
  for (genvar k = 0; k < DecLcStateNumRep; k++) begin : genRep
    assign decState_o[k] = decState;
  end

endmodule

// File: hw/lcPkg.sv
/*
 * Life cycle controller package
 * Sparse OTP encodings, dense decoded views, FSM states
 * and the transition rule and counter conversion helpers
 */

package lcPkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int unsigned LcStateWidth     = 16;
  localparam int unsigned LcCntWidth       = 16;
  localparam int unsigned LcTxWidth        = 4;
  localparam int unsigned DecLcStateWidth  = 5;
  // Number of redundant copies of the decoded state
  localparam int unsigned DecLcStateNumRep = 3;
  localparam int unsigned DecLcCntWidth    = 4;
  // Highest transition count, no transition allowed beyond it
  localparam int unsigned LcCntMax         = 8;
  localparam int unsigned NumStateErrors   = 6;

  //////////////////////////////////////////////////
  // OTP encodings
  //////////////////////////////////////////////////

  // Any two state codes differ in at least 8 bits
  typedef enum logic [LcStateWidth-1:0] {
    LcStRaw           = 16'h0000,
    LcStTestUnlocked0 = 16'h3c5a,
    LcStTestLocked0   = 16'hc3a5,
    LcStDev           = 16'h5a3c,
    LcStProd          = 16'ha5c3,
    LcStProdEnd       = 16'h6996,
    LcStRma           = 16'h9669,
    LcStScrap         = 16'hffff
  } lcStateE;

  // Same distance property, offset so that no count aliases a state
  typedef enum logic [LcCntWidth-1:0] {
    LcCnt0 = 16'h1248,
    LcCnt1 = 16'h2e12,
    LcCnt2 = 16'hd1ed,
    LcCnt3 = 16'h4874,
    LcCnt4 = 16'hb78b,
    LcCnt5 = 16'h7bde,
    LcCnt6 = 16'h8421,
    LcCnt7 = 16'h1db8,
    LcCnt8 = 16'hedb7
  } lcCntE;

  // Multibit boolean, every other code is invalid
  typedef enum logic [LcTxWidth-1:0] {
    On  = 4'b0101,
    Off = 4'b1010
  } lcTxE;

  //////////////////////////////////////////////////
  // Decoded view and FSM
  //////////////////////////////////////////////////

  typedef enum logic [DecLcStateWidth-1:0] {
    DecLcStRaw           = 5'd0,
    DecLcStTestUnlocked0 = 5'd1,
    DecLcStTestLocked0   = 5'd2,
    DecLcStDev           = 5'd3,
    DecLcStProd          = 5'd4,
    DecLcStProdEnd       = 5'd5,
    DecLcStRma           = 5'd6,
    DecLcStScrap         = 5'd7,
    // Temporary states, never stored in OTP
    DecLcStPostTrans     = 5'd8,
    DecLcStEscalate      = 5'd9,
    DecLcStInvalid       = 5'd10
  } decLcStateE;

  typedef enum logic [1:0] {
    DecLcIdBlank        = 2'd0,
    DecLcIdPersonalized = 2'd1,
    DecLcIdInvalid      = 2'd2
  } decLcIdStateE;

  typedef enum logic [2:0] {
    ResetSt     = 3'd0,
    IdleSt      = 3'd1,
    PostTransSt = 3'd2,
    EscalateSt  = 3'd3,
    InvalidSt   = 3'd4,
    ScrapSt     = 3'd5
  } fsmStateE;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Transition matrix lookup, invalid codes on either side are refused
  function automatic logic lcTransAllowed(lcStateE cur, lcStateE tgt);
    logic ok;
    case (cur)
      LcStRaw:           ok = tgt inside {LcStTestUnlocked0, LcStScrap};
      LcStTestUnlocked0: ok = tgt inside {LcStTestLocked0, LcStDev, LcStProd,
                                          LcStRma, LcStScrap};
      LcStTestLocked0:   ok = tgt inside {LcStTestUnlocked0, LcStDev, LcStProd,
                                          LcStScrap};
      LcStDev:           ok = tgt inside {LcStRma, LcStScrap};
      LcStProd:          ok = tgt inside {LcStRma, LcStScrap};
      LcStProdEnd:       ok = (tgt == LcStScrap);
      LcStRma:           ok = (tgt == LcStScrap);
      // Scrap is final
      default:           ok = 1'b0;
    endcase
    return ok;
  endfunction

  // Counter code to number, all ones when the code is invalid
  function automatic logic [DecLcCntWidth-1:0] lcCntToDec(lcCntE cnt);
    logic [DecLcCntWidth-1:0] n;
    case (cnt)
      LcCnt0:  n = 4'd0;
      LcCnt1:  n = 4'd1;
      LcCnt2:  n = 4'd2;
      LcCnt3:  n = 4'd3;
      LcCnt4:  n = 4'd4;
      LcCnt5:  n = 4'd5;
      LcCnt6:  n = 4'd6;
      LcCnt7:  n = 4'd7;
      LcCnt8:  n = 4'd8;
      default: n = {DecLcCntWidth{1'b1}};
    endcase
    return n;
  endfunction

  // Number to counter code, saturates at the top count
  function automatic lcCntE lcCntFromDec(logic [DecLcCntWidth-1:0] n);
    lcCntE cnt;
    case (n)
      4'd0:    cnt = LcCnt0;
      4'd1:    cnt = LcCnt1;
      4'd2:    cnt = LcCnt2;
      4'd3:    cnt = LcCnt3;
      4'd4:    cnt = LcCnt4;
      4'd5:    cnt = LcCnt5;
      4'd6:    cnt = LcCnt6;
      4'd7:    cnt = LcCnt7;
      default: cnt = LcCnt8;
    endcase
    return cnt;
  endfunction

endpackage
